//--- mchan_consts.svh
/* DMA control-port decoder constants
   Widths, register selects and command word field positions */
`ifndef MCHAN_CONSTS_SVH
`define MCHAN_CONSTS_SVH

// Transfer IDs and 2D queue
`define MCHAN_NB_TRANSFERS      4
`define MCHAN_SID_WIDTH         ($clog2(`MCHAN_NB_TRANSFERS))
`define MCHAN_TWD_QUEUE_DEPTH   4
`define MCHAN_TWD_ADD_WIDTH     ($clog2(`MCHAN_TWD_QUEUE_DEPTH))

// Field and address widths
`define MCHAN_LEN_WIDTH         16
`define MCHAN_OPC_WIDTH         1
`define MCHAN_TCDM_ADD_WIDTH    12
`define MCHAN_EXT_ADD_WIDTH     29
`define MCHAN_TWD_COUNT_WIDTH   16
`define MCHAN_TWD_STRIDE_WIDTH  16

// Register selects on address bits 3:2
`define MCHAN_CMD_ADDR          2'd0
`define MCHAN_STATUS_ADDR       2'd1
`define MCHAN_ALLOC_STATUS_LSB  16  // Allocation mask in STATUS read data

// Command word layout
`define MCHAN_CMD_LEN_LSB       0
`define MCHAN_CMD_OPC_BIT       16
`define MCHAN_CMD_INC_BIT       17
`define MCHAN_CMD_TWD_BIT       18
`define MCHAN_CMD_ELE_BIT       19
`define MCHAN_CMD_ILE_BIT       20
`define MCHAN_CMD_BLE_BIT       21

// 2D word layout
`define MCHAN_TWD_COUNT_LSB     0
`define MCHAN_TWD_STRIDE_LSB    16

`endif

//--- mchan_pkg.sv
/* DMA control-port decoder types
   Vector types for the meaningful widths and the control state encoding */
`default_nettype none

`include "mchan_consts.svh"

package mchan_pkg;

   typedef logic [31:0]                          word_t;        // Target port data
   typedef logic [`MCHAN_SID_WIDTH-1:0]          sid_t;
   typedef logic [`MCHAN_NB_TRANSFERS-1:0]       trans_mask_t;  // One bit per ID
   typedef logic [`MCHAN_LEN_WIDTH-1:0]          len_t;
   typedef logic [`MCHAN_OPC_WIDTH-1:0]          opc_t;
   typedef logic [`MCHAN_TWD_ADD_WIDTH-1:0]      twd_add_t;     // 2D queue slot
   typedef logic [`MCHAN_TCDM_ADD_WIDTH-1:0]     tcdm_add_t;
   typedef logic [`MCHAN_EXT_ADD_WIDTH-1:0]      ext_add_t;
   typedef logic [`MCHAN_TWD_COUNT_WIDTH-1:0]    twd_count_t;
   typedef logic [`MCHAN_TWD_STRIDE_WIDTH-1:0]   twd_stride_t;

   // Control sequencing states
   typedef enum logic [3:0]
   {
      IDLE,
      STATUS_GRANTED,
      CLR_GRANTED,
      RET_ID_GRANTED,
      CMD,
      CMD_GRANTED,
      TCDM,
      TCDM_GRANTED,
      EXT,
      EXT_GRANTED,
      TWD,
      TWD_GRANTED,
      TWD_GRANTED_NOWAIT,
      BUSY,
      BUSY2
   } ctrl_state_e;

endpackage

`default_nettype wire

//--- mchan_cmd_unpack.sv
/* Command word unpacker
   Splits a CMD write word into command, address and 2D fields */
`timescale 1ns/1ps
`default_nettype none

`include "mchan_consts.svh"

module mchan_cmd_unpack
   import mchan_pkg::*;
(
   input  wire word_t  data_i,

   // Command word fields
   output len_t        len_o,
   output opc_t        opc_o,
   output logic        inc_o,
   output logic        twd_o,
   output logic        ele_o,
   output logic        ile_o,
   output logic        ble_o,

   // Address words
   output tcdm_add_t   tcdm_add_o,
   output ext_add_t    ext_add_o,

   // 2D word
   output twd_count_t  twd_count_o,
   output twd_stride_t twd_stride_o
);

   len_t        len_raw;
   twd_count_t  count_raw;
   twd_stride_t stride_raw;

   assign len_raw    = data_i[`MCHAN_CMD_LEN_LSB +: `MCHAN_LEN_WIDTH];
   assign count_raw  = data_i[`MCHAN_TWD_COUNT_LSB +: `MCHAN_TWD_COUNT_WIDTH];
   assign stride_raw = data_i[`MCHAN_TWD_STRIDE_LSB +: `MCHAN_TWD_STRIDE_WIDTH];

   // Software writes natural counts, the engine works on count minus one
   assign len_o        = len_raw - len_t'(1);
   assign twd_count_o  = count_raw - twd_count_t'(1);
   assign twd_stride_o = stride_raw - twd_stride_t'(1);

   assign opc_o = data_i[`MCHAN_CMD_OPC_BIT +: `MCHAN_OPC_WIDTH];
   assign inc_o = data_i[`MCHAN_CMD_INC_BIT];  // Incrementing address
   assign twd_o = data_i[`MCHAN_CMD_TWD_BIT];  // 2D transfer, one more word follows
   assign ele_o = data_i[`MCHAN_CMD_ELE_BIT];  // Event line enable
   assign ile_o = data_i[`MCHAN_CMD_ILE_BIT];  // Interrupt line enable
   assign ble_o = data_i[`MCHAN_CMD_BLE_BIT];  // Broadcast enable

   // Addresses sit in the low bits of their words
   assign tcdm_add_o = data_i[`MCHAN_TCDM_ADD_WIDTH-1:0];
   assign ext_add_o  = data_i[`MCHAN_EXT_ADD_WIDTH-1:0];

endmodule

`default_nettype wire

//--- mchan_trans_regs.sv
/* Transfer bookkeeping registers
   Allocated ID, 2D queue slot and the pending 2D flag */
`timescale 1ns/1ps
`default_nettype none

module mchan_trans_regs
   import mchan_pkg::*;
(
   input  wire           clk_i,
   input  wire           rst_ni,

   input  wire           trans_alloc_req_i,
   input  wire           trans_alloc_gnt_i,
   input  wire sid_t     trans_alloc_ret_i,

   input  wire           twd_alloc_req_i,
   input  wire           twd_alloc_gnt_i,
   input  wire twd_add_t twd_alloc_add_i,

   input  wire           cmd_req_i,
   input  wire           cmd_gnt_i,
   input  wire           cmd_twd_i,
   input  wire           twd_queue_req_i,

   output sid_t          sid_o,
   output twd_add_t      twd_add_o,
   output logic          twd_trans_o
);

   sid_t     sid_q;
   twd_add_t twd_add_q;
   logic     twd_trans_q;

   // ID returned by the allocator
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         sid_q <= '0;
      end
      else if (trans_alloc_req_i && trans_alloc_gnt_i)
      begin
         sid_q <= trans_alloc_ret_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         twd_add_q <= '0;
      end
      else if (twd_alloc_req_i && twd_alloc_gnt_i)
      begin
         twd_add_q <= twd_alloc_add_i;  // Slot reserved with the command
      end
   end

   // Set by a 2D command, cleared once its 2D word is queued
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         twd_trans_q <= 1'b0;
      end
      else if (cmd_req_i && cmd_gnt_i && cmd_twd_i)
      begin
         twd_trans_q <= 1'b1;
      end
      else if (twd_queue_req_i)
      begin
         twd_trans_q <= 1'b0;
      end
   end

   assign sid_o       = sid_q;
   assign twd_add_o   = twd_add_q;
   assign twd_trans_o = twd_trans_q;

endmodule

`default_nettype wire

//--- mchan_ctrl_fsm.sv
/* Control port sequencer
   Grants target accesses, strobes the command FIFOs and builds read data */
`timescale 1ns/1ps
`default_nettype none

`include "mchan_consts.svh"

module mchan_ctrl_fsm
   import mchan_pkg::*;
(
   input  wire              clk_i,
   input  wire              rst_ni,

   // Target port
   input  wire              ctrl_targ_req_i,
   input  wire              ctrl_targ_type_i,   // 1 = read
   input  wire logic [1:0]  reg_sel_i,
   input  wire word_t       ctrl_targ_data_i,
   output logic             ctrl_targ_gnt_o,
   output logic             ctrl_targ_r_valid_o,
   output word_t            ctrl_targ_r_data_o,

   // Downstream grants
   input  wire              cmd_gnt_i,
   input  wire              cmd_twd_i,
   input  wire              tcdm_gnt_i,
   input  wire              ext_gnt_i,
   input  wire              twd_alloc_gnt_i,
   input  wire              trans_alloc_gnt_i,

   // Synchronisation arbiter
   input  wire              arb_req_i,
   input  wire              arb_gnt_i,
   input  wire sid_t        arb_sid_i,

   // Stored transfer state
   input  wire sid_t        sid_i,
   input  wire              twd_trans_i,
   input  wire trans_mask_t trans_status_i,
   input  wire trans_mask_t trans_alloc_status_i,

   // Requests
   output logic             cmd_req_o,
   output logic             tcdm_req_o,
   output logic             ext_req_o,
   output logic             twd_alloc_req_o,
   output logic             twd_queue_req_o,
   output logic             trans_alloc_req_o,
   output trans_mask_t      trans_alloc_clr_o,
   output logic             busy_o
);

   ctrl_state_e state_q;
   ctrl_state_e state_d;

   logic        wr_cmd;      // Write to the CMD register
   logic        cmd_ok;      // Command word can be taken now
   logic        arb_match;   // Arbiter serves our own ID
   ctrl_state_e busy_next;

   assign wr_cmd    = !ctrl_targ_type_i && (reg_sel_i == `MCHAN_CMD_ADDR);
   assign cmd_ok    = cmd_gnt_i && (!cmd_twd_i || twd_alloc_gnt_i);
   assign arb_match = arb_req_i && arb_gnt_i && (arb_sid_i == sid_i);
   assign busy_next = arb_match ? BUSY2 : BUSY;

   //**************************************************
   // State register
   //**************************************************
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q <= IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   //**************************************************
   // Next state and outputs
   //**************************************************
   always_comb
   begin
      state_d             = state_q;
      ctrl_targ_gnt_o     = 1'b0;
      ctrl_targ_r_valid_o = 1'b0;
      ctrl_targ_r_data_o  = '0;
      cmd_req_o           = 1'b0;
      tcdm_req_o          = 1'b0;
      ext_req_o           = 1'b0;
      twd_alloc_req_o     = 1'b0;
      twd_queue_req_o     = 1'b0;
      trans_alloc_req_o   = 1'b0;
      trans_alloc_clr_o   = '0;
      busy_o              = 1'b1;

      case (state_q)
         IDLE:
         begin
            busy_o = ctrl_targ_req_i;
            if (ctrl_targ_req_i)
            begin
               case (reg_sel_i)
                  `MCHAN_CMD_ADDR:
                  begin
                     if (ctrl_targ_type_i)
                     begin
                        trans_alloc_req_o = 1'b1;  // Held until an ID is free
                        if (trans_alloc_gnt_i)
                        begin
                           ctrl_targ_gnt_o = 1'b1;
                           state_d         = RET_ID_GRANTED;
                        end
                     end
                     else if (cmd_ok)  // Otherwise stall here
                     begin
                        ctrl_targ_gnt_o = 1'b1;
                        cmd_req_o       = 1'b1;
                        twd_alloc_req_o = cmd_twd_i;
                        state_d         = CMD_GRANTED;
                     end
                  end
                  `MCHAN_STATUS_ADDR:
                  begin
                     ctrl_targ_gnt_o = 1'b1;  // Never stalls
                     if (ctrl_targ_type_i)
                     begin
                        state_d = STATUS_GRANTED;
                     end
                     else
                     begin
                        trans_alloc_clr_o = ctrl_targ_data_i[`MCHAN_NB_TRANSFERS-1:0];
                        state_d           = CLR_GRANTED;
                     end
                  end
                  default:
                  begin
                     state_d = IDLE;
                  end
               endcase
            end
         end

         STATUS_GRANTED:
         begin
            ctrl_targ_r_valid_o = 1'b1;
            ctrl_targ_r_data_o[`MCHAN_NB_TRANSFERS-1:0] = trans_status_i;
            ctrl_targ_r_data_o[`MCHAN_ALLOC_STATUS_LSB +: `MCHAN_NB_TRANSFERS] =
               trans_alloc_status_i;
            state_d = IDLE;
         end

         CLR_GRANTED:
         begin
            ctrl_targ_r_valid_o = 1'b1;
            state_d             = IDLE;
         end

         // Command word, possibly right behind the ID read response
         RET_ID_GRANTED, CMD:
         begin
            if (state_q == RET_ID_GRANTED)
            begin
               ctrl_targ_r_valid_o = 1'b1;
               ctrl_targ_r_data_o  = word_t'(sid_i);
            end
            state_d = CMD;
            if (ctrl_targ_req_i && cmd_gnt_i)
            begin
               if (!wr_cmd)
               begin
                  state_d = IDLE;  // Broken sequence
               end
               else if (cmd_ok)
               begin
                  ctrl_targ_gnt_o = 1'b1;
                  cmd_req_o       = 1'b1;
                  twd_alloc_req_o = cmd_twd_i;
                  state_d         = CMD_GRANTED;
               end
            end
         end

         // TCDM address word
         CMD_GRANTED, TCDM:
         begin
            ctrl_targ_r_valid_o = (state_q == CMD_GRANTED);
            state_d             = TCDM;
            if (ctrl_targ_req_i && tcdm_gnt_i)
            begin
               state_d = IDLE;
               if (wr_cmd)
               begin
                  ctrl_targ_gnt_o = 1'b1;
                  tcdm_req_o      = 1'b1;
                  state_d         = TCDM_GRANTED;
               end
            end
         end

         // External address word
         TCDM_GRANTED, EXT:
         begin
            ctrl_targ_r_valid_o = (state_q == TCDM_GRANTED);
            state_d             = EXT;
            if (ctrl_targ_req_i && ext_gnt_i)
            begin
               state_d = IDLE;
               if (wr_cmd)
               begin
                  ctrl_targ_gnt_o = 1'b1;
                  ext_req_o       = 1'b1;
                  state_d         = EXT_GRANTED;
               end
            end
         end

         // Optional 2D word, then wait for the arbiter
         EXT_GRANTED, TWD:
         begin
            ctrl_targ_r_valid_o = (state_q == EXT_GRANTED);
            if ((state_q == EXT_GRANTED) && !twd_trans_i)
            begin
               state_d = busy_next;  // 1D transfer complete
            end
            else if (!ctrl_targ_req_i)
            begin
               state_d = TWD;
            end
            else if (wr_cmd)
            begin
               ctrl_targ_gnt_o = 1'b1;
               twd_queue_req_o = 1'b1;  // Queue has no grant
               state_d         = arb_match ? TWD_GRANTED_NOWAIT : TWD_GRANTED;
            end
            else
            begin
               state_d = (state_q == TWD) ? IDLE : busy_next;
            end
         end

         TWD_GRANTED:
         begin
            ctrl_targ_r_valid_o = 1'b1;
            state_d             = busy_next;
         end

         TWD_GRANTED_NOWAIT:
         begin
            ctrl_targ_r_valid_o = 1'b1;
            state_d             = BUSY2;
         end

         BUSY:
         begin
            state_d = busy_next;
         end

         // Own ID arbitrated, wait for its completion
         BUSY2:
         begin
            if (trans_status_i[sid_i])
            begin
               state_d = IDLE;
            end
         end

         default:
         begin
            state_d = IDLE;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- mchan_addr_decoder.sv
/* DMA control-port command decoder
   Turns target port writes into command FIFO entries and serves ID and status reads */
`timescale 1ns/1ps
`default_nettype none

module mchan_addr_decoder
   import mchan_pkg::*;
(
   input  wire              clk_i,
   input  wire              rst_ni,

   // Control target port
   input  wire              ctrl_targ_req_i,
   input  wire              ctrl_targ_type_i,
   input  wire word_t       ctrl_targ_add_i,
   input  wire word_t       ctrl_targ_data_i,
   output logic             ctrl_targ_gnt_o,
   output logic             ctrl_targ_r_valid_o,
   output word_t            ctrl_targ_r_data_o,

   // Command FIFO
   input  wire              cmd_gnt_i,
   output logic             cmd_req_o,
   output len_t             cmd_len_o,
   output opc_t             cmd_opc_o,
   output logic             cmd_inc_o,
   output logic             cmd_twd_o,
   output logic             cmd_ele_o,
   output logic             cmd_ile_o,
   output logic             cmd_ble_o,
   output twd_add_t         cmd_twd_add_o,
   output sid_t             cmd_sid_o,

   // Address FIFOs
   input  wire              tcdm_gnt_i,
   output logic             tcdm_req_o,
   output tcdm_add_t        tcdm_add_o,
   input  wire              ext_gnt_i,
   output logic             ext_req_o,
   output ext_add_t         ext_add_o,

   // Synchronisation arbiter
   input  wire              arb_req_i,
   input  wire              arb_gnt_i,
   input  wire sid_t        arb_sid_i,

   // 2D queue
   output logic             twd_trans_o,
   output logic             twd_alloc_req_o,
   input  wire              twd_alloc_gnt_i,
   input  wire twd_add_t    twd_alloc_add_i,
   output logic             twd_queue_req_o,
   output twd_add_t         twd_queue_add_o,
   output twd_count_t       twd_queue_count_o,
   output twd_stride_t      twd_queue_stride_o,
   output sid_t             twd_queue_sid_o,

   // Transfer ID allocation and status
   output logic             trans_alloc_req_o,
   input  wire              trans_alloc_gnt_i,
   input  wire sid_t        trans_alloc_ret_i,
   output trans_mask_t      trans_alloc_clr_o,
   input  wire trans_mask_t trans_alloc_status_i,
   input  wire trans_mask_t trans_status_i,

   output logic             busy_o
);

   sid_t     sid;       // Current transfer ID
   twd_add_t twd_add;   // Reserved 2D slot

   mchan_cmd_unpack mchan_cmd_unpack_i
   (
      .data_i       ( ctrl_targ_data_i   ),
      .len_o        ( cmd_len_o          ),
      .opc_o        ( cmd_opc_o          ),
      .inc_o        ( cmd_inc_o          ),
      .twd_o        ( cmd_twd_o          ),
      .ele_o        ( cmd_ele_o          ),
      .ile_o        ( cmd_ile_o          ),
      .ble_o        ( cmd_ble_o          ),
      .tcdm_add_o   ( tcdm_add_o         ),
      .ext_add_o    ( ext_add_o          ),
      .twd_count_o  ( twd_queue_count_o  ),
      .twd_stride_o ( twd_queue_stride_o )
   );

   mchan_ctrl_fsm mchan_ctrl_fsm_i
   (
      .clk_i                ( clk_i                 ),
      .rst_ni               ( rst_ni                ),
      .ctrl_targ_req_i      ( ctrl_targ_req_i       ),
      .ctrl_targ_type_i     ( ctrl_targ_type_i      ),
      .reg_sel_i            ( ctrl_targ_add_i[3:2]  ),  // Word select
      .ctrl_targ_data_i     ( ctrl_targ_data_i      ),
      .ctrl_targ_gnt_o      ( ctrl_targ_gnt_o       ),
      .ctrl_targ_r_valid_o  ( ctrl_targ_r_valid_o   ),
      .ctrl_targ_r_data_o   ( ctrl_targ_r_data_o    ),
      .cmd_gnt_i            ( cmd_gnt_i             ),
      .cmd_twd_i            ( cmd_twd_o             ),
      .tcdm_gnt_i           ( tcdm_gnt_i            ),
      .ext_gnt_i            ( ext_gnt_i             ),
      .twd_alloc_gnt_i      ( twd_alloc_gnt_i       ),
      .trans_alloc_gnt_i    ( trans_alloc_gnt_i     ),
      .arb_req_i            ( arb_req_i             ),
      .arb_gnt_i            ( arb_gnt_i             ),
      .arb_sid_i            ( arb_sid_i             ),
      .sid_i                ( sid                   ),
      .twd_trans_i          ( twd_trans_o           ),
      .trans_status_i       ( trans_status_i        ),
      .trans_alloc_status_i ( trans_alloc_status_i  ),
      .cmd_req_o            ( cmd_req_o             ),
      .tcdm_req_o           ( tcdm_req_o            ),
      .ext_req_o            ( ext_req_o             ),
      .twd_alloc_req_o      ( twd_alloc_req_o       ),
      .twd_queue_req_o      ( twd_queue_req_o       ),
      .trans_alloc_req_o    ( trans_alloc_req_o     ),
      .trans_alloc_clr_o    ( trans_alloc_clr_o     ),
      .busy_o               ( busy_o                )
   );

   mchan_trans_regs mchan_trans_regs_i
   (
      .clk_i             ( clk_i             ),
      .rst_ni            ( rst_ni            ),
      .trans_alloc_req_i ( trans_alloc_req_o ),
      .trans_alloc_gnt_i ( trans_alloc_gnt_i ),
      .trans_alloc_ret_i ( trans_alloc_ret_i ),
      .twd_alloc_req_i   ( twd_alloc_req_o   ),
      .twd_alloc_gnt_i   ( twd_alloc_gnt_i   ),
      .twd_alloc_add_i   ( twd_alloc_add_i   ),
      .cmd_req_i         ( cmd_req_o         ),
      .cmd_gnt_i         ( cmd_gnt_i         ),
      .cmd_twd_i         ( cmd_twd_o         ),
      .twd_queue_req_i   ( twd_queue_req_o   ),
      .sid_o             ( sid               ),
      .twd_add_o         ( twd_add           ),
      .twd_trans_o       ( twd_trans_o       )
   );

   // The command carries the slot granted with it, the 2D word the stored one
   assign cmd_twd_add_o   = twd_alloc_add_i;
   assign twd_queue_add_o = twd_add;
   assign cmd_sid_o       = sid;
   assign twd_queue_sid_o = sid;

endmodule

`default_nettype wire

//--- tb_mchan_addr_decoder.sv
/* Testbench for the DMA control-port command decoder
   Random grant, allocation, arbiter and completion models with assertion checks */
`timescale 1ns/1ps
`default_nettype none

`include "mchan_consts.svh"

module tb_mchan_addr_decoder
   import mchan_pkg::*;
();

   localparam int NUM_TRANSFERS       = 20;
   localparam int CYCLES_PER_TRANSFER = 200;
   localparam int CLK_PERIOD          = 20;

   logic        clk_i = 1'b0;
   logic        rst_ni;
   logic        ctrl_targ_req_i, ctrl_targ_type_i;
   word_t       ctrl_targ_add_i, ctrl_targ_data_i;
   logic        ctrl_targ_gnt_o, ctrl_targ_r_valid_o;
   word_t       ctrl_targ_r_data_o;
   logic        cmd_gnt_i = 1'b0;
   logic        tcdm_gnt_i = 1'b0;
   logic        ext_gnt_i = 1'b0;
   logic        arb_req_i = 1'b0;
   logic        arb_gnt_i = 1'b0;
   sid_t        arb_sid_i = '0;
   logic        twd_alloc_gnt_i = 1'b0;
   twd_add_t    twd_alloc_add_i = '0;
   logic        trans_alloc_gnt_i = 1'b0;
   sid_t        trans_alloc_ret_i = '0;     // Allocation counter
   trans_mask_t trans_alloc_status_i = '0;
   trans_mask_t trans_status_i = '0;
   logic        cmd_req_o, cmd_inc_o, cmd_twd_o, cmd_ele_o, cmd_ile_o, cmd_ble_o;
   len_t        cmd_len_o;
   opc_t        cmd_opc_o;
   twd_add_t    cmd_twd_add_o, twd_queue_add_o;
   sid_t        cmd_sid_o, twd_queue_sid_o;
   logic        tcdm_req_o, ext_req_o;
   tcdm_add_t   tcdm_add_o;
   ext_add_t    ext_add_o;
   logic        twd_trans_o, twd_alloc_req_o, twd_queue_req_o;
   twd_count_t  twd_queue_count_o;
   twd_stride_t twd_queue_stride_o;
   logic        trans_alloc_req_o, busy_o;
   trans_mask_t trans_alloc_clr_o;

   // Model state and expected values
   logic [31:0] stim_state = 32'hcc1c;
   logic [31:0] model_state = 32'hcc1c;
   logic        waiting;                 // Last word granted, completion pending
   logic        armed = 1'b0;
   logic [2:0]  done_cnt = '0;
   logic        twd_exp = 1'b0;
   sid_t        exp_sid = '0;
   twd_add_t    exp_slot = '0;
   word_t       status_exp = '0;         // Status masks of the previous cycle
   int          value_errs = 0;
   int          rule_errs = 0;
   int          n_done = 0;

   mchan_addr_decoder mchan_addr_decoder_i (.*);

   always #(CLK_PERIOD/2) clk_i = ~clk_i;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic word_t next_stim();
      stim_state = lcg_next(stim_state);
      return stim_state;
   endfunction

   task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] act);
      value_errs++;
      $display("FAIL @%0t ns: %s expected %0h, got %0h", $time, name, exp, act);
   endtask

   task automatic report_rule(input string what);
      rule_errs++;
      $display("ERROR @%0t ns: %s", $time, what);
   endtask

   // **************************************************
   // Grant, allocation, arbiter and completion models
   // **************************************************
   always @(posedge clk_i)
   begin : models
      logic [31:0] r;
      trans_mask_t status_n;
      trans_mask_t alloc_n;
      model_state = lcg_next(model_state);
      r = model_state;
      cmd_gnt_i         <= r[31] | r[30];
      tcdm_gnt_i        <= r[29] | r[28];
      ext_gnt_i         <= r[27] | r[26];
      twd_alloc_gnt_i   <= r[25] | r[24];
      trans_alloc_gnt_i <= r[23];
      twd_alloc_add_i   <= r[22:21];
      arb_req_i         <= r[20];
      arb_gnt_i         <= r[19] | r[18];
      arb_sid_i         <= r[17:16];   // Hits the own ID now and then
      status_exp        <= {12'd0, trans_alloc_status_i, 12'd0, trans_status_i};
      twd_exp           <= (cmd_req_o && cmd_twd_o) || (twd_exp && !twd_queue_req_o);
      status_n = trans_status_i & ~trans_alloc_clr_o;
      alloc_n  = trans_alloc_status_i & ~trans_alloc_clr_o;
      if (trans_alloc_req_o && trans_alloc_gnt_i)
      begin
         status_n[trans_alloc_ret_i] = 1'b0;
         alloc_n[trans_alloc_ret_i]  = 1'b1;
         exp_sid           <= trans_alloc_ret_i;
         trans_alloc_ret_i <= trans_alloc_ret_i + 2'd1;
      end
      if (twd_alloc_req_o && twd_alloc_gnt_i)
      begin
         exp_slot <= twd_alloc_add_i;
      end
      // Completion some cycles after the arbiter serves the ID
      if (armed)
      begin
         if (done_cnt == 3'd0)
         begin
            status_n[exp_sid] = 1'b1;
            armed <= 1'b0;
         end
         else
         begin
            done_cnt <= done_cnt - 3'd1;
         end
      end
      else if (waiting && arb_req_i && arb_gnt_i && (arb_sid_i == exp_sid) &&
               !trans_status_i[exp_sid])
      begin
         armed    <= 1'b1;
         done_cnt <= r[15:13];
      end
      trans_status_i       <= status_n;
      trans_alloc_status_i <= alloc_n;
   end

   // Decoded target accesses
   logic [1:0] sel;
   logic       status_req, status_rd, clr_wr, id_rd, cmd_wr, strobe_bad;
   logic [23:0] cmd_exp, cmd_act;
   logic [35:0] queue_exp, queue_act;

   assign sel        = ctrl_targ_add_i[3:2];
   assign status_req = ctrl_targ_req_i && ctrl_targ_type_i && (sel == `MCHAN_STATUS_ADDR);
   assign status_rd  = status_req && ctrl_targ_gnt_o;
   assign clr_wr     = ctrl_targ_req_i && ctrl_targ_gnt_o && !ctrl_targ_type_i &&
                       (sel == `MCHAN_STATUS_ADDR);
   assign id_rd      = ctrl_targ_req_i && ctrl_targ_gnt_o && ctrl_targ_type_i &&
                       (sel == `MCHAN_CMD_ADDR);
   assign cmd_wr     = ctrl_targ_req_i && ctrl_targ_gnt_o && !ctrl_targ_type_i &&
                       (sel == `MCHAN_CMD_ADDR);
   assign strobe_bad = (cmd_req_o && !cmd_gnt_i) || (tcdm_req_o && !tcdm_gnt_i) ||
                       (ext_req_o && !ext_gnt_i) || (twd_alloc_req_o && !twd_alloc_gnt_i) ||
                       ((cmd_req_o || tcdm_req_o || ext_req_o || twd_queue_req_o) &&
                        !ctrl_targ_gnt_o);
   assign cmd_exp    = {ctrl_targ_data_i[15:0] - 16'd1, ctrl_targ_data_i[16],
                        ctrl_targ_data_i[17], ctrl_targ_data_i[18], ctrl_targ_data_i[19],
                        ctrl_targ_data_i[20], ctrl_targ_data_i[21], exp_sid};
   assign cmd_act    = {cmd_len_o, cmd_opc_o, cmd_inc_o, cmd_twd_o, cmd_ele_o, cmd_ile_o,
                        cmd_ble_o, cmd_sid_o};
   assign queue_exp  = {exp_slot, ctrl_targ_data_i[15:0] - 16'd1,
                        ctrl_targ_data_i[31:16] - 16'd1, exp_sid};
   assign queue_act  = {twd_queue_add_o, twd_queue_count_o, twd_queue_stride_o,
                        twd_queue_sid_o};

   // **************************************************
   // Checks
   // **************************************************
   a_status_rd: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $past(status_rd) |-> {ctrl_targ_r_valid_o, ctrl_targ_r_data_o} == {1'b1, status_exp})
      else report_value("ctrl_targ_r_data_o", 64'({1'b1, status_exp}),
                        64'({ctrl_targ_r_valid_o, ctrl_targ_r_data_o}));
   a_clr: assert property (@(posedge clk_i) disable iff (!rst_ni)
      clr_wr |-> trans_alloc_clr_o == ctrl_targ_data_i[3:0])
      else report_value("trans_alloc_clr_o", 64'(ctrl_targ_data_i[3:0]), 64'(trans_alloc_clr_o));
   a_clr_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $past(clr_wr) |-> ctrl_targ_r_valid_o)
      else report_rule("no r_valid after a STATUS write");
   a_id_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      id_rd |-> trans_alloc_req_o && trans_alloc_gnt_i)
      else report_rule("ID read granted without an allocation request and grant");
   a_id_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $past(id_rd) |-> {ctrl_targ_r_valid_o, ctrl_targ_r_data_o} == {1'b1, 30'd0, exp_sid})
      else report_value("ctrl_targ_r_data_o", 64'({1'b1, 30'd0, exp_sid}),
                        64'({ctrl_targ_r_valid_o, ctrl_targ_r_data_o}));
   a_cmd: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cmd_req_o |-> cmd_act == cmd_exp)
      else report_value("cmd fields", 64'(cmd_exp), 64'(cmd_act));
   a_tcdm: assert property (@(posedge clk_i) disable iff (!rst_ni)
      tcdm_req_o |-> tcdm_add_o == ctrl_targ_data_i[11:0])
      else report_value("tcdm_add_o", 64'(ctrl_targ_data_i[11:0]), 64'(tcdm_add_o));
   a_ext: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ext_req_o |-> ext_add_o == ctrl_targ_data_i[28:0])
      else report_value("ext_add_o", 64'(ctrl_targ_data_i[28:0]), 64'(ext_add_o));
   a_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni) !strobe_bad)
      else report_rule("FIFO strobe raised without its grant or a target grant");
   a_cmd_wr: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cmd_wr |-> (cmd_req_o && cmd_gnt_i) || (tcdm_req_o && tcdm_gnt_i) ||
                 (ext_req_o && ext_gnt_i) || twd_queue_req_o)
      else report_rule("CMD write granted while the downstream grant was low");
   a_twd_slot: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cmd_req_o && cmd_twd_o |-> twd_alloc_req_o && (cmd_twd_add_o == twd_alloc_add_i))
      else report_rule("2D command without a matching slot allocation");
   a_twd_flag: assert property (@(posedge clk_i) disable iff (!rst_ni)
      twd_trans_o == twd_exp)
      else report_value("twd_trans_o", 64'(twd_exp), 64'(twd_trans_o));
   a_twd_queue: assert property (@(posedge clk_i) disable iff (!rst_ni)
      twd_queue_req_o |-> queue_act == queue_exp)
      else report_value("twd_queue fields", 64'(queue_exp), 64'(queue_act));
   a_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
      waiting && !$past(trans_status_i[exp_sid]) |-> busy_o && !ctrl_targ_gnt_o)
      else report_rule("decoder left busy before its transfer completed");
   a_idle_rd: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !$past(busy_o) && status_req |-> ctrl_targ_gnt_o)
      else report_rule("STATUS read not granted in an idle cycle");

   // One target access, held until granted
   task automatic access(input logic rd, input logic [1:0] reg_sel, input word_t data);
      word_t upper;
      upper = next_stim();
      @(posedge clk_i);
      ctrl_targ_req_i  <= 1'b1;
      ctrl_targ_type_i <= rd;
      ctrl_targ_add_i  <= {upper[31:4], reg_sel, 2'b00};
      ctrl_targ_data_i <= data;
      @(negedge clk_i);
      while (!ctrl_targ_gnt_o)
      begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
      ctrl_targ_req_i <= 1'b0;
   endtask

   task automatic run_transfer(input logic twd);
      word_t cmd;
      cmd = next_stim();
      cmd[`MCHAN_CMD_TWD_BIT] = twd;
      access(1'b1, `MCHAN_CMD_ADDR, next_stim());      // ID read
      access(1'b0, `MCHAN_CMD_ADDR, cmd);
      access(1'b0, `MCHAN_CMD_ADDR, next_stim());      // TCDM address
      access(1'b0, `MCHAN_CMD_ADDR, next_stim());      // External address
      if (twd)
      begin
         access(1'b0, `MCHAN_CMD_ADDR, next_stim());   // Count and stride
      end
      waiting <= 1'b1;
      @(negedge clk_i);
      while (busy_o)
      begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
      waiting <= 1'b0;
   endtask

   initial
   begin
      int i;
      rst_ni           = 1'b0;
      ctrl_targ_req_i  = 1'b0;
      ctrl_targ_type_i = 1'b0;
      ctrl_targ_add_i  = '0;
      ctrl_targ_data_i = '0;
      waiting          = 1'b0;
      repeat (2) @(posedge clk_i);
      rst_ni <= 1'b1;
      for (i = 0; i < NUM_TRANSFERS; i++)
      begin
         access(1'b1, `MCHAN_STATUS_ADDR, next_stim());
         run_transfer(i[0]);                              // Odd transfers are 2D
         access(1'b1, `MCHAN_STATUS_ADDR, next_stim());   // Straight after busy falls
         access(1'b0, `MCHAN_STATUS_ADDR, next_stim());   // Random clear mask
         n_done++;
      end
      repeat (2) @(posedge clk_i);
      $display("Run complete: %0d transfers, %0d value errors, %0d other errors",
               n_done, value_errs, rule_errs);
      if (value_errs + rule_errs == 0)
      begin
         $display("TEST RESULT: PASS");
      end
      else
      begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // Watchdog sized from the transfer count
   initial
   begin
      #(NUM_TRANSFERS * CYCLES_PER_TRANSFER * CLK_PERIOD);
      $display("Timeout: run did not finish after %0d transfers", n_done);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
mchan_pkg.sv
mchan_cmd_unpack.sv
mchan_trans_regs.sv
mchan_ctrl_fsm.sv
mchan_addr_decoder.sv
tb_mchan_addr_decoder.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the control-port decoder testbench
cd "$(dirname "$0")" || exit 1

TOP=tb_mchan_addr_decoder
LOG=sim.log

rm -rf obj_dir "$LOG" build.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f verilog.f --top-module "$TOP" -o "$TOP" > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/"$TOP" > "$LOG" 2>&1
cat "$LOG"

grep -q "TEST RESULT: PASS" "$LOG" && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
